// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

   // datapath widths
   localparam int WORD_W    = 32;
   localparam int WADDR_W   = 30;
   localparam int REG_IDX_W = 5;
   localparam int BE_W      = 4;
   localparam int NUM_REGS  = 32;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [WADDR_W-1:0]   waddr_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   // bit k enables the byte at offset k, little-endian
   typedef logic [BE_W-1:0]      be_t;

   // reset pc, byte address
   localparam word_t    TEXT_START = 32'h0040_0000;
   localparam reg_idx_t REG_ZERO   = 5'd0;

   // primary opcodes that the core executes
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_t;

   // funct field of the special opcode
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_ADD  = 6'h20,
      FN_ADDU = 6'h21,
      FN_SUB  = 6'h22,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI
   } alu_op_t;

   typedef enum logic [3:0] {
      MEM_NONE, MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU, MEM_SW, MEM_SH, MEM_SB
   } mem_op_t;

   // true for the five load flavours
   function automatic logic is_load(mem_op_t op);
      return op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
   endfunction

endpackage

`default_nettype wire

// ==== mips_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_fetch import mips_pkg::*; (
   input  logic   clk,
   input  logic   rst_b,
   input  logic   stall,
   input  word_t  inst,
   output waddr_t inst_addr,
   output word_t  fetched
);

   // pc is kept as a word address, one word per cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_addr <= waddr_t'(TEXT_START >> 2);
         // all-zero word decodes as sll $0,$0,0
         fetched   <= '0;
      end else if (!stall) begin
         inst_addr <= inst_addr + 1'b1;
         fetched   <= inst;
      end
      // on stall both hold, so inst_addr repeats once
   end

endmodule

`default_nettype wire

// ==== mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   output word_t    rs_data,
   output word_t    rt_data,
   input  logic     wb_we,
   input  reg_idx_t wb_reg,
   input  word_t    wb_data
);

   word_t regs [NUM_REGS];
   logic  wr_en;

   // register 0 is never written, so it stays at its reset value of zero
   assign wr_en = wb_we && (wb_reg != REG_ZERO);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // same-cycle writeback bypasses the array
   assign rs_data = (wr_en && wb_reg == rs) ? wb_data : regs[rs];
   assign rt_data = (wr_en && wb_reg == rt) ? wb_data : regs[rt];

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  word_t    fetched,
   input  word_t    rs_data,
   input  word_t    rt_data,
   input  reg_idx_t ex_dst,
   input  logic     ex_is_load,
   output reg_idx_t rs,
   output reg_idx_t rt,
   output logic     stall,
   output alu_op_t  id_alu_op,
   output mem_op_t  id_mem_op,
   output reg_idx_t id_rs,
   output reg_idx_t id_rt,
   output word_t    id_rs_data,
   output word_t    id_rt_data,
   output word_t    id_imm,
   output reg_idx_t id_dst,
   output logic     id_we
);

   opcode_t  opcode;
   funct_t   funct;
   reg_idx_t rd;
   logic [4:0]  shamt;
   logic [15:0] imm16;
   alu_op_t  alu_op;
   mem_op_t  mem_op;
   reg_idx_t dst;
   logic     we;
   word_t    imm;
   // rt is read as a source (r-type and stores), not a destination
   logic     rt_src;

   // instruction fields
   assign opcode = opcode_t'(fetched[31:26]);
   assign rs     = fetched[25:21];
   assign rt     = fetched[20:16];
   assign rd     = fetched[15:11];
   assign shamt  = fetched[10:6];
   assign funct  = funct_t'(fetched[5:0]);
   assign imm16  = fetched[15:0];

   always_comb begin
      alu_op = ALU_ADD;
      mem_op = MEM_NONE;
      dst    = rt;
      we     = 1'b1;
      rt_src = 1'b0;
      // sign-extended unless the opcode says otherwise
      imm    = {{16{imm16[15]}}, imm16};
      case (opcode)
         OP_SPECIAL: begin
            dst    = rd;
            rt_src = 1'b1;
            // shift amount rides in the immediate
            imm    = {27'd0, shamt};
            case (funct)
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_SLLV: alu_op = ALU_SLLV;
               FN_SRLV: alu_op = ALU_SRLV;
               FN_SRAV: alu_op = ALU_SRAV;
               FN_ADD, FN_ADDU: alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               // unknown funct becomes a bubble
               default: we = 1'b0;
            endcase
         end
         OP_ADDIU: alu_op = ALU_ADD;
         OP_SLTI:  alu_op = ALU_SLT;
         OP_SLTIU: alu_op = ALU_SLTU;
         OP_ANDI: begin
            alu_op = ALU_AND;
            imm    = {16'd0, imm16};
         end
         OP_ORI: begin
            alu_op = ALU_OR;
            imm    = {16'd0, imm16};
         end
         OP_XORI: begin
            alu_op = ALU_XOR;
            imm    = {16'd0, imm16};
         end
         OP_LUI:  alu_op = ALU_LUI;
         OP_LB:   mem_op = MEM_LB;
         OP_LH:   mem_op = MEM_LH;
         OP_LW:   mem_op = MEM_LW;
         OP_LBU:  mem_op = MEM_LBU;
         OP_LHU:  mem_op = MEM_LHU;
         OP_SB, OP_SH, OP_SW: begin
            mem_op = (opcode == OP_SB) ? MEM_SB : (opcode == OP_SH) ? MEM_SH : MEM_SW;
            we     = 1'b0;
            rt_src = 1'b1;
         end
         // unknown opcode becomes a bubble
         default: we = 1'b0;
      endcase
   end

   // load in execute feeding a source here: one cycle, then the bubble clears it
   assign stall = ex_is_load && (ex_dst != REG_ZERO) &&
                  ((ex_dst == rs) || (rt_src && ex_dst == rt));

   // decode/execute control, bubble on reset and on stall
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_alu_op <= ALU_ADD;
         id_mem_op <= MEM_NONE;
         id_rs     <= REG_ZERO;
         id_rt     <= REG_ZERO;
         id_dst    <= REG_ZERO;
         id_we     <= 1'b0;
      end else if (stall) begin
         id_alu_op <= ALU_ADD;
         id_mem_op <= MEM_NONE;
         id_rs     <= REG_ZERO;
         id_rt     <= REG_ZERO;
         id_dst    <= REG_ZERO;
         id_we     <= 1'b0;
      end else begin
         id_alu_op <= alu_op;
         id_mem_op <= mem_op;
         id_rs     <= rs;
         // rt index zeroed when rt is not a source so nothing forwards over it
         id_rt     <= rt_src ? rt : REG_ZERO;
         id_dst    <= dst;
         id_we     <= we;
      end
   end

   // payload, the immediate takes the rt slot for i-type alu operations
   always_ff @(posedge clk) begin
      id_rs_data <= rs_data;
      id_rt_data <= rt_src ? rt_data : imm;
      id_imm     <= imm;
   end

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  alu_op_t  id_alu_op,
   input  mem_op_t  id_mem_op,
   input  reg_idx_t id_rs,
   input  reg_idx_t id_rt,
   input  word_t    id_rs_data,
   input  word_t    id_rt_data,
   input  word_t    id_imm,
   input  reg_idx_t id_dst,
   input  logic     id_we,
   input  logic     wb_we,
   input  reg_idx_t wb_reg,
   input  word_t    wb_data,
   output reg_idx_t ex_dst,
   output logic     ex_is_load,
   output word_t    ex_result,
   output word_t    ex_store,
   output mem_op_t  ex_mem_op,
   output logic     ex_we
);

   word_t rs_fwd;
   word_t rt_fwd;
   word_t op_a;
   word_t op_b;
   word_t alu_out;
   // memory stage holds an alu result, a load there has no data yet
   logic  mem_fwd_ok;

   // for the hazard check in decode
   assign ex_is_load = id_we && is_load(id_mem_op);
   assign mem_fwd_ok = ex_we && !is_load(ex_mem_op);

   // memory stage first, then writeback, then the decode read
   always_comb begin
      rs_fwd = id_rs_data;
      if (id_rs != REG_ZERO && mem_fwd_ok && ex_dst == id_rs)
         rs_fwd = ex_result;
      else if (id_rs != REG_ZERO && wb_we && wb_reg == id_rs)
         rs_fwd = wb_data;
      rt_fwd = id_rt_data;
      if (id_rt != REG_ZERO && mem_fwd_ok && ex_dst == id_rt)
         rt_fwd = ex_result;
      else if (id_rt != REG_ZERO && wb_we && wb_reg == id_rt)
         rt_fwd = wb_data;
   end

   // address offset for memory ops; for i-type alu ops rt_fwd already is the immediate
   assign op_a = rs_fwd;
   assign op_b = (id_mem_op == MEM_NONE) ? rt_fwd : id_imm;

   always_comb begin
      case (id_alu_op)
         ALU_ADD:  alu_out = op_a + op_b;
         ALU_SUB:  alu_out = op_a - op_b;
         ALU_AND:  alu_out = op_a & op_b;
         ALU_OR:   alu_out = op_a | op_b;
         ALU_XOR:  alu_out = op_a ^ op_b;
         ALU_NOR:  alu_out = ~(op_a | op_b);
         ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: alu_out = {31'd0, op_a < op_b};
         // constant shifts take shamt from the immediate
         ALU_SLL:  alu_out = op_b << id_imm[4:0];
         ALU_SRL:  alu_out = op_b >> id_imm[4:0];
         ALU_SRA:  alu_out = $signed(op_b) >>> id_imm[4:0];
         // variable shifts take it from rs
         ALU_SLLV: alu_out = op_b << op_a[4:0];
         ALU_SRLV: alu_out = op_b >> op_a[4:0];
         ALU_SRAV: alu_out = $signed(op_b) >>> op_a[4:0];
         ALU_LUI:  alu_out = {id_imm[15:0], 16'd0};
         default:  alu_out = op_a + op_b;
      endcase
   end

   // execute/memory control
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem_op <= MEM_NONE;
         ex_dst    <= REG_ZERO;
         ex_we     <= 1'b0;
      end else begin
         ex_mem_op <= id_mem_op;
         ex_dst    <= id_dst;
         ex_we     <= id_we;
      end
   end

   always_ff @(posedge clk) begin
      ex_result <= alu_out;
      ex_store  <= rt_fwd;
   end

endmodule

`default_nettype wire

// ==== mips_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_memory import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  word_t    ex_result,
   input  word_t    ex_store,
   input  mem_op_t  ex_mem_op,
   input  reg_idx_t ex_dst,
   input  logic     ex_we,
   output waddr_t   mem_addr,
   output word_t    mem_wdata,
   output be_t      mem_be,
   input  word_t    mem_rdata,
   output logic     wb_we,
   output reg_idx_t wb_reg,
   output word_t    wb_data
);

   logic [1:0]  offset;
   logic [4:0]  lane_shift;
   word_t       lane;
   word_t       load_val;

   assign mem_addr   = ex_result[WORD_W-1:2];
   assign offset     = ex_result[1:0];
   assign lane_shift = {offset, 3'b000};

   // store lanes, aligned addresses only
   always_comb begin
      mem_wdata = ex_store;
      mem_be    = '0;
      case (ex_mem_op)
         MEM_SW: mem_be = 4'b1111;
         MEM_SH: begin
            mem_wdata = {16'd0, ex_store[15:0]} << lane_shift;
            mem_be    = 4'b0011 << offset;
         end
         MEM_SB: begin
            mem_wdata = {24'd0, ex_store[7:0]} << lane_shift;
            mem_be    = 4'b0001 << offset;
         end
         default: mem_be = '0;
      endcase
   end

   // addressed byte or halfword moved down to bit 0
   assign lane = mem_rdata >> lane_shift;

   always_comb begin
      case (ex_mem_op)
         MEM_LB:  load_val = {{24{lane[7]}}, lane[7:0]};
         MEM_LBU: load_val = {24'd0, lane[7:0]};
         MEM_LH:  load_val = {{16{lane[15]}}, lane[15:0]};
         MEM_LHU: load_val = {16'd0, lane[15:0]};
         default: load_val = mem_rdata;
      endcase
   end

   // memory/writeback control
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_we  <= 1'b0;
         wb_reg <= REG_ZERO;
      end else begin
         wb_we  <= ex_we;
         wb_reg <= ex_dst;
      end
   end

   always_ff @(posedge clk) begin
      wb_data <= is_load(ex_mem_op) ? load_val : ex_result;
   end

endmodule

`default_nettype wire

// ==== mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
   input  logic   clk,
   input  logic   rst_b,
   output waddr_t inst_addr,
   input  word_t  inst,
   output waddr_t mem_addr,
   output word_t  mem_wdata,
   output be_t    mem_be,
   input  word_t  mem_rdata
);

   // fetch to decode
   word_t    fetched;
   logic     stall;
   // decode to register file
   reg_idx_t rs;
   reg_idx_t rt;
   word_t    rs_data;
   word_t    rt_data;
   // decode/execute register
   alu_op_t  id_alu_op;
   mem_op_t  id_mem_op;
   reg_idx_t id_rs;
   reg_idx_t id_rt;
   word_t    id_rs_data;
   word_t    id_rt_data;
   word_t    id_imm;
   reg_idx_t id_dst;
   logic     id_we;
   // execute/memory register and hazard info
   logic     ex_is_load;
   reg_idx_t ex_dst;
   word_t    ex_result;
   word_t    ex_store;
   mem_op_t  ex_mem_op;
   logic     ex_we;
   // writeback register
   logic     wb_we;
   reg_idx_t wb_reg;
   word_t    wb_data;

   mips_fetch fetch_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .stall     (stall),
      .inst      (inst),
      .inst_addr (inst_addr),
      .fetched   (fetched)
   );

   mips_regfile regfile_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (rs),
      .rt      (rt),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wb_we   (wb_we),
      .wb_reg  (wb_reg),
      .wb_data (wb_data)
   );

   // the hazard check looks at the instruction now in execute
   mips_decode decode_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .fetched    (fetched),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .ex_dst     (id_dst),
      .ex_is_load (ex_is_load),
      .rs         (rs),
      .rt         (rt),
      .stall      (stall),
      .id_alu_op  (id_alu_op),
      .id_mem_op  (id_mem_op),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_rs_data (id_rs_data),
      .id_rt_data (id_rt_data),
      .id_imm     (id_imm),
      .id_dst     (id_dst),
      .id_we      (id_we)
   );

   mips_execute execute_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .id_alu_op  (id_alu_op),
      .id_mem_op  (id_mem_op),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_rs_data (id_rs_data),
      .id_rt_data (id_rt_data),
      .id_imm     (id_imm),
      .id_dst     (id_dst),
      .id_we      (id_we),
      .wb_we      (wb_we),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data),
      .ex_dst     (ex_dst),
      .ex_is_load (ex_is_load),
      .ex_result  (ex_result),
      .ex_store   (ex_store),
      .ex_mem_op  (ex_mem_op),
      .ex_we      (ex_we)
   );

   mips_memory memory_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .ex_result (ex_result),
      .ex_store  (ex_store),
      .ex_mem_op (ex_mem_op),
      .ex_dst    (ex_dst),
      .ex_we     (ex_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_be    (mem_be),
      .mem_rdata (mem_rdata),
      .wb_we     (wb_we),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data)
   );

endmodule

`default_nettype wire

// ==== tb_mips_model.svh ====
// r-type instruction word from its fields
function automatic word_t enc_r(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                logic [4:0] sh);
   return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

// i-type instruction word
function automatic word_t enc_i(opcode_t op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// runs prog in order, queues every store and returns the count of load-use pairs
function automatic int run_reference();
   word_t      regs [32];
   word_t      mem [64];
   word_t      iw, a, b, simm, zimm, addr, lanes, res, wdata;
   opcode_t    op;
   funct_t     fn;
   reg_idx_t   rs, rt, rd, dst, prev_load;
   logic [4:0] sh;
   logic [1:0] off;
   be_t        be;
   logic       wr;
   int         stalls;
   stalls    = 0;
   prev_load = 5'd0;
   for (int i = 0; i < 32; i++) regs[i] = '0;
   for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
   for (int pc = 0; pc < prog_len; pc++) begin
      iw   = prog[pc];
      op   = opcode_t'(iw[31:26]);
      fn   = funct_t'(iw[5:0]);
      rs   = iw[25:21];
      rt   = iw[20:16];
      rd   = iw[15:11];
      sh   = iw[10:6];
      simm = {{16{iw[15]}}, iw[15:0]};
      zimm = {16'd0, iw[15:0]};
      // previous load read here as a source costs one cycle
      if (prev_load != 0 && (rs == prev_load ||
          ((op == OP_SPECIAL || op inside {OP_SB, OP_SH, OP_SW}) && rt == prev_load)))
         stalls++;
      prev_load = 5'd0;
      a     = regs[rs];
      b     = regs[rt];
      addr  = a + simm;
      off   = addr[1:0];
      lanes = mem[addr[7:2]] >> {off, 3'b000};
      wr    = 1'b1;
      dst   = rt;
      res   = '0;
      be    = '0;
      wdata = '0;
      case (op)
         OP_SPECIAL: begin
            dst = rd;
            case (fn)
               FN_SLL:          res = b << sh;
               FN_SRL:          res = b >> sh;
               FN_SRA:          res = $signed(b) >>> sh;
               FN_SLLV:         res = b << a[4:0];
               FN_SRLV:         res = b >> a[4:0];
               FN_SRAV:         res = $signed(b) >>> a[4:0];
               FN_ADD, FN_ADDU: res = a + b;
               FN_SUB, FN_SUBU: res = a - b;
               FN_AND:          res = a & b;
               FN_OR:           res = a | b;
               FN_XOR:          res = a ^ b;
               FN_NOR:          res = ~(a | b);
               FN_SLT:          res = {31'd0, $signed(a) < $signed(b)};
               FN_SLTU:         res = {31'd0, a < b};
               default:         wr = 1'b0;
            endcase
         end
         OP_ADDIU: res = a + simm;
         OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
         OP_SLTIU: res = {31'd0, a < simm};
         OP_ANDI:  res = a & zimm;
         OP_ORI:   res = a | zimm;
         OP_XORI:  res = a ^ zimm;
         OP_LUI:   res = {iw[15:0], 16'd0};
         OP_LB:    res = {{24{lanes[7]}}, lanes[7:0]};
         OP_LBU:   res = {24'd0, lanes[7:0]};
         OP_LH:    res = {{16{lanes[15]}}, lanes[15:0]};
         OP_LHU:   res = {16'd0, lanes[15:0]};
         OP_LW:    res = lanes;
         OP_SB: begin
            wr    = 1'b0;
            wdata = {24'd0, b[7:0]} << {off, 3'b000};
            be    = 4'b0001 << off;
         end
         OP_SH: begin
            wr    = 1'b0;
            wdata = {16'd0, b[15:0]} << {off, 3'b000};
            be    = 4'b0011 << off;
         end
         OP_SW: begin
            wr    = 1'b0;
            wdata = b;
            be    = 4'b1111;
         end
         default: wr = 1'b0;
      endcase
      if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) prev_load = rt;
      // r0 stays zero whatever is written
      if (wr && dst != 0) regs[dst] = res;
      if (be != 0) begin
         for (int k = 0; k < 4; k++)
            if (be[k]) mem[addr[7:2]][8*k +: 8] = wdata[8*k +: 8];
         exp_addr.push_back(waddr_t'(addr[31:2]));
         exp_data.push_back(wdata);
         exp_be.push_back(be);
      end
   end
   return stalls;
endfunction

// ==== tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

   localparam int     PROG_MAX   = 256;
   localparam waddr_t TEXT_WADDR = waddr_t'(TEXT_START >> 2);

   logic   clk;
   logic   rst_b;
   waddr_t inst_addr;
   word_t  inst;
   waddr_t mem_addr;
   word_t  mem_wdata;
   be_t    mem_be;
   word_t  mem_rdata;

   word_t  prog [PROG_MAX];
   int     prog_len;
   word_t  dmem [64];
   integer seed;
   // expected stores in program order
   waddr_t exp_addr [$];
   word_t  exp_data [$];
   be_t    exp_be [$];
   int     lu_count;
   int     limit;
   int     cycles;
   int     repeats;
   waddr_t prev_inst_addr;
   logic   started;
   logic   done;
   waddr_t inst_idx;

   // initial data memory where every word differs with its address
   function automatic word_t fill_word(int i);
      word_t w;
      w = 32'h9e37_79b9 * (i + 1);
      return w ^ {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'h5a};
   endfunction

   `include "tb_mips_model.svh"

   mips_core mips_core_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_be    (mem_be),
      .mem_rdata (mem_rdata)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // instruction memory starts at the reset pc and reads nops outside the program
   assign inst_idx = inst_addr - TEXT_WADDR;
   assign inst     = (inst_idx < prog_len) ? prog[inst_idx[7:0]] : '0;
   assign mem_rdata = dmem[mem_addr[5:0]];

   always @(posedge clk) begin
      for (int k = 0; k < 4; k++)
         if (mem_be[k]) dmem[mem_addr[5:0]][8*k +: 8] <= mem_wdata[8*k +: 8];
   end

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_addr(string name, waddr_t got, waddr_t exp);
      if (got !== exp) fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      if (got !== exp) fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_be(string name, be_t got, be_t exp);
      if (got !== exp) fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
   endtask

   function automatic int rnd(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic void emit(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endfunction

   // random aligned byte address in words 0..31 for an access of size bytes
   function automatic logic [15:0] rand_addr(int size);
      return 16'(rnd(32) * 4 + (rnd(4 / size) * size));
   endfunction

   function automatic funct_t pick_funct(int k);
      case (k)
         0: return FN_SLL;
         1: return FN_SRL;
         2: return FN_SRA;
         3: return FN_SLLV;
         4: return FN_SRLV;
         5: return FN_SRAV;
         6: return FN_ADD;
         7: return FN_SUBU;
         8: return FN_AND;
         9: return FN_OR;
         10: return FN_XOR;
         11: return FN_NOR;
         12: return FN_SLT;
         default: return FN_SLTU;
      endcase
   endfunction

   task automatic build_program();
      word_t    v;
      reg_idx_t last, d, s, t;
      funct_t   fn;
      opcode_t  op;
      int       size;
      last = 5'd1;
      for (int r = 1; r < 16; r++) begin
         v = $random(seed);
         emit(enc_i(OP_LUI, reg_idx_t'(r), 5'd0, v[31:16]));
         emit(enc_i(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), v[15:0]));
      end
      // write to r0 that must be discarded
      emit(enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
      for (int it = 0; it < 60; it++) begin
         case (rnd(10))
            0, 1, 2, 3: begin
               d  = reg_idx_t'(rnd(16));
               s  = rnd(2) ? last : reg_idx_t'(rnd(16));
               t  = reg_idx_t'(rnd(16));
               fn = pick_funct(rnd(14));
               // constant shifts keep rs at zero
               if (fn inside {FN_SLL, FN_SRL, FN_SRA})
                  emit(enc_r(fn, d, 5'd0, s, 5'(rnd(32))));
               else
                  emit(enc_r(fn, d, s, t, 5'd0));
               if (d != 0) last = d;
            end
            4, 5: begin
               d = reg_idx_t'(1 + rnd(15));
               s = rnd(2) ? last : reg_idx_t'(rnd(16));
               v = $random(seed);
               case (rnd(7))
                  0: op = OP_ADDIU;
                  1: op = OP_SLTI;
                  2: op = OP_SLTIU;
                  3: op = OP_ANDI;
                  4: op = OP_ORI;
                  5: op = OP_XORI;
                  default: op = OP_LUI;
               endcase
               emit(enc_i(op, d, (op == OP_LUI) ? 5'd0 : s, v[15:0]));
               last = d;
            end
            6, 7: begin
               case (rnd(5))
                  0: op = OP_LB;
                  1: op = OP_LBU;
                  2: op = OP_LH;
                  3: op = OP_LHU;
                  default: op = OP_LW;
               endcase
               size = (op inside {OP_LB, OP_LBU}) ? 1 : (op == OP_LW) ? 4 : 2;
               d    = reg_idx_t'(1 + rnd(15));
               emit(enc_i(op, d, 5'd0, rand_addr(size)));
               // use right after the load
               t    = reg_idx_t'(1 + rnd(15));
               if (rnd(2)) emit(enc_r(FN_ADDU, t, d, reg_idx_t'(rnd(16)), 5'd0));
               else emit(enc_r(FN_ADDU, t, reg_idx_t'(rnd(16)), d, 5'd0));
               last = t;
            end
            default: begin
               case (rnd(3))
                  0: op = OP_SB;
                  1: op = OP_SH;
                  default: op = OP_SW;
               endcase
               size = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
               emit(enc_i(op, reg_idx_t'(rnd(16)), 5'd0, rand_addr(size)));
            end
         endcase
      end
      // final register dump to words 32..47
      for (int r = 0; r < 16; r++)
         emit(enc_i(OP_SW, reg_idx_t'(r), 5'd0, 16'(128 + 4 * r)));
      for (int n = 0; n < 5; n++) emit('0);
   endtask

   initial begin
      rst_b    = 1'b0;
      seed     = 32'hf063_01db;
      prog_len = 0;
      cycles   = 0;
      repeats  = 0;
      started  = 1'b0;
      done     = 1'b0;
      build_program();
      for (int i = 0; i < 64; i++) dmem[i] = fill_word(i);
      lu_count = run_reference();
      limit    = prog_len + lu_count + 10;
      repeat (3) @(posedge clk);
      check_addr("inst_addr", inst_addr, TEXT_WADDR);
      check_be("mem_be", mem_be, '0);
      rst_b <= 1'b1;
      wait (done);
      if (repeats == lu_count) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         fail_run($sformatf("inst_addr repeated %0d times but %0d load-use pairs ran",
                            repeats, lu_count));
      end
   end

   // compare, stall count and timeout run mid-cycle where outputs are settled
   always @(negedge clk) begin
      be_t    b;
      word_t  mask;
      waddr_t a;
      word_t  d;
      if (rst_b && !done) begin
         cycles++;
         if (cycles > limit)
            fail_run($sformatf("timeout after %0d cycles, %0d stores never seen",
                               cycles, exp_addr.size()));
         if (started && inst_addr == prev_inst_addr) repeats++;
         prev_inst_addr = inst_addr;
         started        = 1'b1;
         if (mem_be != 0) begin
            if (exp_addr.size() == 0) fail_run("store seen after the last expected store");
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            b = exp_be.pop_front();
            for (int k = 0; k < 4; k++) mask[8*k +: 8] = {8{b[k]}};
            check_addr("mem_addr", mem_addr, a);
            check_be("mem_be", mem_be, b);
            check_word("mem_wdata", mem_wdata & mask, d & mask);
         end
         // the last nop of the program is in the memory stage now
         if (exp_addr.size() == 0 && inst_idx >= prog_len + 2) done = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_regfile.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_core.sv
tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - mips_fetch.sv
  - mips_regfile.sv
  - mips_decode.sv
  - mips_execute.sv
  - mips_memory.sv
  - mips_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mips_core.sv
